// File: sim.f
hw/ws_periph_pkg.sv
hw/periph_decoder.sv
hw/pixel_fifo.sv
hw/ws2812b_serializer.sv
hw/ws_periph_top.sv
tb/ws_periph_checker.sv
tb/ws_periph_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module ws_periph_tb -f sim.f -o ws_periph_sim

./obj_dir/ws_periph_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run passed"
    exit 0
else
    echo "run failed, see sim.log"
    exit 1
fi

// File: tb/ws_periph_tb.sv
`timescale 1ns/1ps

module ws_periph_tb;

    localparam int kind_write = 0;
    localparam int kind_read  = 1;
    localparam int kind_pixel = 2;
    localparam int bit_cycles = ws_periph_pkg::t_short + ws_periph_pkg::t_long;
    localparam int reg_wait   = 50;
    localparam int pixel_wait = 2 * ws_periph_pkg::pixel_bits * bit_cycles;  // Slot frees per pixel

    typedef struct {
        int          kind;
        logic [15:0] addr;
        logic [15:0] data;
        logic [23:0] expected;
    } entry_t;

    logic        clk;
    logic        rst;
    logic        mem_valid;
    logic        nwr;
    logic [15:0] address;
    logic [15:0] wdata;
    logic        mem_ready;
    logic [15:0] rdata;
    logic        button1;
    logic        button2;
    logic        scl_in;
    logic        sda_in;
    logic        scl_oe;
    logic        sda_oe;
    logic [4:0]  dac1_code;
    logic [4:0]  dac2_code;
    logic        dout;
    logic        busy;

    entry_t      table_q[$];
    logic [23:0] expect_q[$];
    logic [23:0] obs_q[$];
    logic [31:0] lfsr_state;
    logic [15:0] model_state;  // {4'b0, scl_oe, sda_oe, dac2, dac1}
    int          err_count;
    int          test_count;
    int          failed_tests;

    int          hi_cnt;
    int          since_rise;
    int          nbits;
    int          bad_period;
    logic        in_run;
    logic        dout_q;
    logic [23:0] word;

    ws_periph_top ws_periph_top_i (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .nwr       (nwr),
        .address   (address),
        .wdata     (wdata),
        .mem_ready (mem_ready),
        .rdata     (rdata),
        .button1   (button1),
        .button2   (button2),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe),
        .dac1_code (dac1_code),
        .dac2_code (dac2_code),
        .dout      (dout),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Pulse decoder on dout, sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            hi_cnt     = 0;
            since_rise = 0;
            nbits      = 0;
            bad_period = 0;
            in_run     = 1'b0;
            dout_q     = 1'b0;
            word       = '0;
        end else begin
            if (dout && !dout_q) begin
                if (in_run && since_rise != bit_cycles) begin
                    bad_period++;
                end
                since_rise = 0;
                in_run     = 1'b1;
            end
            if (dout) begin
                hi_cnt++;
            end else if (dout_q) begin
                word   = {word[22:0], hi_cnt > bit_cycles / 2};  // Long pulse is a one
                hi_cnt = 0;
                nbits++;
                if (nbits == ws_periph_pkg::pixel_bits) begin
                    obs_q.push_back(word);
                    nbits = 0;
                end
            end
            since_rise++;
            dout_q = dout;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // RGB565 to GRB, 8 bits per channel
    function automatic logic [23:0] expand_rgb(input logic [15:0] px);
        return {2'b00, px[10:5], 2'b00, px[15:11], 1'b0, 2'b00, px[4:0], 1'b0};
    endfunction

    function automatic logic [15:0] state_word();
        return {4'b0, scl_oe, sda_oe, dac2_code, dac1_code};
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("error at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
            err_count++;
        end
    endtask

    task automatic add_entry(input int kind, input logic [15:0] addr, input logic [15:0] data,
                             input logic [23:0] expected);
        entry_t e;
        e.kind     = kind;
        e.addr     = addr;
        e.data     = data;
        e.expected = expected;
        table_q.push_back(e);
    endtask

    task automatic add_write(input logic [15:0] addr, input logic [15:0] data);
        case (addr[15:13])
            ws_periph_pkg::region_i2c: begin
                model_state[11] = ~data[1];  // Pulled low unless released
                model_state[10] = ~data[0];
            end
            ws_periph_pkg::region_dac1: model_state[4:0] = data[4:0];
            ws_periph_pkg::region_dac2: model_state[9:5] = data[4:0];
            default: ;
        endcase
        add_entry(kind_write, addr, data, {8'h00, model_state});
    endtask

    task automatic add_read(input logic [15:0] addr, input logic [3:0] levels);
        if (addr[15:13] == ws_periph_pkg::region_i2c) begin
            add_entry(kind_read, addr, {12'h0, levels}, {20'h0, levels});
        end else begin
            add_entry(kind_read, addr, {12'h0, levels}, 24'h0);
        end
    endtask

    task automatic add_pixel(input logic [15:0] data);
        add_entry(kind_pixel, {ws_periph_pkg::region_led, 13'h0}, data, expand_rgb(data));
    endtask

    task automatic bus_transfer(input logic write, input logic [15:0] addr,
                                input logic [15:0] data, input int limit,
                                output logic [15:0] rd, output int cycles);
        cycles = 0;
        @(posedge clk);
        #1;
        mem_valid = 1'b1;
        nwr       = !write;
        address   = addr;
        wdata     = data;
        @(negedge clk);
        while (mem_ready !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (mem_ready !== 1'b1) begin
            $display("timeout: no mem_ready within %0d cycles for address %h", limit, addr);
            err_count++;
        end
        rd = rdata;
        @(posedge clk);
        #1;
        mem_valid = 1'b0;
        nwr       = 1'b1;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [15:0] data, input int limit,
                             output int cycles);
        logic [15:0] unused;
        bus_transfer(1'b1, addr, data, limit, unused, cycles);
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [15:0] rd, output int cycles);
        bus_transfer(1'b0, addr, 16'h0, reg_wait, rd, cycles);
    endtask

    task automatic wait_pixels(input int count);
        int n;
        int limit;
        n     = 0;
        limit = (count + 1) * ws_periph_pkg::pixel_bits * bit_cycles;
        while (obs_q.size() < count && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (obs_q.size() < count) begin
            $display("timeout: only %0d of %0d pixels came out on dout", obs_q.size(), count);
            err_count++;
        end
        n = 0;
        while (busy !== 1'b0 && n < 2 * bit_cycles) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            $display("timeout: serializer still busy after the last pixel");
            err_count++;
        end
    endtask

    task automatic compare_pixels();
        check(obs_q.size(), expect_q.size(), "pixel count");
        for (int i = 0; i < expect_q.size() && i < obs_q.size(); i++) begin
            check(32'(obs_q[i]), 32'(expect_q[i]), $sformatf("GRB word of pixel %0d", i));
        end
        check(bad_period, 0, "rise to rise spacing other than 33 cycles");
        obs_q.delete();
        expect_q.delete();
        bad_period = 0;
        in_run     = 1'b0;  // Next run starts fresh
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic run_entries(input int first, input int last, input string name);
        entry_t      e;
        logic [15:0] rd;
        int          cycles;
        int          errs_before;
        errs_before = err_count;
        for (int i = first; i < last; i++) begin
            e = table_q[i];
            case (e.kind)
                kind_write: begin
                    bus_write(e.addr, e.data, reg_wait, cycles);
                    check(cycles, 1, "mem_ready latency");
                    check(32'(state_word()), 32'(e.expected), $sformatf("state after %h", e.addr));
                end
                kind_read: begin
                    {button1, button2, scl_in, sda_in} = e.data[3:0];
                    bus_read(e.addr, rd, cycles);
                    check(cycles, 1, "mem_ready latency");
                    check(32'(rd), 32'(e.expected), $sformatf("read data of %h", e.addr));
                end
                default: begin
                    bus_write(e.addr, e.data, pixel_wait, cycles);
                    expect_q.push_back(e.expected);
                end
            endcase
        end
        if (expect_q.size() > 0) begin
            wait_pixels(expect_q.size());
            compare_pixels();
        end
        report_test(name, errs_before);
    endtask

    initial begin
        int          mark;
        int          errs;
        logic [31:0] r;
        rst          = 1'b1;
        mem_valid    = 1'b0;
        nwr          = 1'b1;
        address      = '0;
        wdata        = '0;
        button1      = 1'b0;
        button2      = 1'b0;
        scl_in       = 1'b1;
        sda_in       = 1'b1;
        lfsr_state   = 32'h1eac_169d;
        model_state  = '0;
        err_count    = 0;
        test_count   = 0;
        failed_tests = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        errs = err_count;
        @(negedge clk);
        check(32'(state_word()), 0, "register state after reset");
        check(32'({mem_ready, dout, busy}), 0, "mem_ready, dout and busy after reset");
        report_test("reset values", errs);

        mark = table_q.size();
        add_write({ws_periph_pkg::region_dac1, 13'h0000}, 16'h0ff3);
        add_write({ws_periph_pkg::region_dac2, 13'h0000}, 16'h0009);
        add_write({ws_periph_pkg::region_dac1, 13'h0123}, 16'h001c);
        add_write({ws_periph_pkg::region_dac2, 13'h1fff}, 16'hffe5);
        run_entries(mark, table_q.size(), "dac registers");

        mark = table_q.size();
        add_write({ws_periph_pkg::region_i2c, 13'h0000}, 16'h0001);
        add_write({ws_periph_pkg::region_i2c, 13'h0004}, 16'h0002);
        add_write({3'd5, 13'h0000}, 16'hffff);  // Unused region
        add_write({ws_periph_pkg::region_i2c, 13'h0000}, 16'h0003);
        run_entries(mark, table_q.size(), "i2c control");

        mark = table_q.size();
        for (int i = 0; i < 4; i++) begin
            rand_bits(4, r);
            add_read({ws_periph_pkg::region_i2c, 13'h0000}, r[3:0]);
        end
        rand_bits(4, r);
        add_read({3'd5, 13'h0040}, r[3:0]);
        run_entries(mark, table_q.size(), "register reads");

        mark = table_q.size();
        add_pixel(16'hac35);
        run_entries(mark, table_q.size(), "single pixel");

        mark = table_q.size();
        for (int i = 0; i < 10; i++) begin
            rand_bits(16, r);
            add_pixel(r[15:0]);
        end
        run_entries(mark, table_q.size(), "pixel burst");

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tb/ws_periph_checker.sv
`timescale 1ns/1ps

module ws_periph_checker (
    input logic clk,
    input logic rst,
    input logic mem_valid,
    input logic mem_ready,
    input logic push,
    input logic full,
    input logic pop,
    input logic empty
);

    a_ready_valid: assert property (@(posedge clk) disable iff (rst) mem_ready |-> mem_valid)
        else $error("mem_ready raised without mem_valid");

    // One answer per transfer
    a_ready_pulse: assert property (@(posedge clk) disable iff (rst) mem_ready |=> !mem_ready)
        else $error("mem_ready high for two cycles in a row");

    a_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push while the FIFO is full");

    a_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("pop while the FIFO is empty");

endmodule

// Decoder handshake and both FIFO ports, all visible at the top level
bind ws_periph_top ws_periph_checker periph_chk_i (
    .clk       (clk),
    .rst       (rst),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .push      (push),
    .full      (full),
    .pop       (pop),
    .empty     (empty)
);

// File: hw/ws_periph_top.sv
`timescale 1ns/1ps

module ws_periph_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_valid,
    input  logic        nwr,
    input  logic [15:0] address,
    input  logic [15:0] wdata,
    output logic        mem_ready,
    output logic [15:0] rdata,
    input  logic        button1,
    input  logic        button2,
    input  logic        scl_in,
    input  logic        sda_in,
    output logic        scl_oe,
    output logic        sda_oe,
    output logic [4:0]  dac1_code,
    output logic [4:0]  dac2_code,
    output logic        dout,
    output logic        busy
);

    logic        push;
    logic [15:0] push_data;
    logic        pop;
    logic [15:0] pop_data;
    logic        full;
    logic        empty;

    periph_decoder decoder_i (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .nwr       (nwr),
        .address   (address),
        .wdata     (wdata),
        .button1   (button1),
        .button2   (button2),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .full      (full),
        .mem_ready (mem_ready),
        .rdata     (rdata),
        .dac1_code (dac1_code),
        .dac2_code (dac2_code),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe),
        .push      (push),
        .push_data (push_data)
    );

    pixel_fifo fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    ws2812b_serializer serializer_i (
        .clk      (clk),
        .rst      (rst),
        .empty    (empty),
        .pop_data (pop_data),
        .pop      (pop),
        .dout     (dout),
        .busy     (busy)
    );

endmodule

// File: hw/ws2812b_serializer.sv
`timescale 1ns/1ps

module ws2812b_serializer (
    input  logic        clk,
    input  logic        rst,
    input  logic        empty,
    input  logic [15:0] pop_data,
    output logic        pop,
    output logic        dout,
    output logic        busy
);

    ws_periph_pkg::bus_word_u head;

    logic [ws_periph_pkg::pixel_bits-1:0] grb;
    logic [ws_periph_pkg::pixel_bits-1:0] shift;
    logic [4:0]                           bit_cnt;
    logic [5:0]                           cyc_cnt;
    logic [5:0]                           high_time;
    logic                                 active;
    logic                                 last_cycle;
    logic                                 last_bit;

    assign head = pop_data;

    // RGB565 widened to 8-bit channels, green first on the wire
    assign grb = {2'b00, head.rgb.green,
                  2'b00, head.rgb.red, 1'b0,
                  2'b00, head.rgb.blue, 1'b0};

    assign high_time = shift[ws_periph_pkg::pixel_bits-1] ? 6'(ws_periph_pkg::t_long)
                                                           : 6'(ws_periph_pkg::t_short);

    assign last_cycle = cyc_cnt == 6'(ws_periph_pkg::t_short + ws_periph_pkg::t_long - 1);
    assign last_bit   = bit_cnt == 5'(ws_periph_pkg::pixel_bits - 1);

    // Take a word when idle or right at the end of a pixel
    assign pop = !empty && (!active || (last_cycle && last_bit));

    assign dout = active && (cyc_cnt < high_time);
    assign busy = active;

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            bit_cnt <= '0;
            cyc_cnt <= '0;
        end else if (pop) begin
            active  <= 1'b1;
            bit_cnt <= '0;
            cyc_cnt <= '0;
        end else if (active) begin
            if (last_cycle) begin
                cyc_cnt <= '0;
                if (last_bit) begin
                    active <= 1'b0;  // Nothing waiting, latch gap follows
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (pop) begin
            shift <= grb;
        end else if (active && last_cycle) begin
            shift <= {shift[ws_periph_pkg::pixel_bits-2:0], 1'b0};
        end
    end

endmodule

// File: hw/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  logic [15:0] push_data,
    input  logic        pop,
    output logic [15:0] pop_data,
    output logic        full,
    output logic        empty
);

    ws_periph_pkg::bus_word_u mem [ws_periph_pkg::fifo_depth];

    logic [ws_periph_pkg::fifo_ptr_bits-1:0] wr_ptr;
    logic [ws_periph_pkg::fifo_ptr_bits-1:0] rd_ptr;
    logic [ws_periph_pkg::fifo_ptr_bits:0]   count;
    logic                                    do_push;
    logic                                    do_pop;

    assign full  = count == (ws_periph_pkg::fifo_ptr_bits + 1)'(ws_periph_pkg::fifo_depth);
    assign empty = count == '0;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign pop_data = mem[rd_ptr];  // Head word, shown before the pop

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

endmodule

// File: hw/periph_decoder.sv
`timescale 1ns/1ps

module periph_decoder (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_valid,
    input  logic        nwr,
    input  logic [15:0] address,
    input  logic [15:0] wdata,
    input  logic        button1,
    input  logic        button2,
    input  logic        scl_in,
    input  logic        sda_in,
    input  logic        full,
    output logic        mem_ready,
    output logic [15:0] rdata,
    output logic [4:0]  dac1_code,
    output logic [4:0]  dac2_code,
    output logic        scl_oe,
    output logic        sda_oe,
    output logic        push,
    output logic [15:0] push_data
);

    logic [2:0]               region;
    logic                     led_wr;
    logic                     answer;
    logic                     pending;
    logic                     scl_release;
    logic                     sda_release;
    ws_periph_pkg::bus_word_u wword;

    assign region = address[15:13];
    assign wword  = wdata;
    assign led_wr = (region == ws_periph_pkg::region_led) && !nwr;

    // Pixel writes wait here while the FIFO is full
    assign answer = mem_valid && !pending && !(led_wr && full);

    // Open drain: pull the line low unless it is released
    assign scl_oe = ~scl_release;
    assign sda_oe = ~sda_release;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_ready <= 1'b0;
            push      <= 1'b0;
            pending   <= 1'b0;
        end else begin
            mem_ready <= answer;
            push      <= answer && led_wr;
            if (answer) begin
                pending <= 1'b1;
            end else if (!mem_valid) begin
                pending <= 1'b0;  // Transfer finished
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dac1_code   <= 5'd0;
            dac2_code   <= 5'd0;
            scl_release <= 1'b1;
            sda_release <= 1'b1;
        end else if (answer && !nwr) begin
            case (region)
                ws_periph_pkg::region_i2c: begin
                    scl_release <= wword.ctrl.scl_release;
                    sda_release <= wword.ctrl.sda_release;
                end
                ws_periph_pkg::region_dac1: dac1_code <= wword.dac.code;
                ws_periph_pkg::region_dac2: dac2_code <= wword.dac.code;
                default: ;  // Other regions ignore writes
            endcase
        end
    end

    // Read data and pixel word, valid alongside mem_ready and push
    always_ff @(posedge clk) begin
        if (answer) begin
            push_data <= wword;
            if (nwr && region == ws_periph_pkg::region_i2c) begin
                rdata <= {12'b0, button1, button2, scl_in, sda_in};
            end else begin
                rdata <= 16'd0;
            end
        end
    end

endmodule

// File: hw/ws_periph_pkg.sv
package ws_periph_pkg;

    // Address window regions, taken from address[15:13]
    localparam logic [2:0] region_i2c  = 3'd0;
    localparam logic [2:0] region_dac1 = 3'd2;
    localparam logic [2:0] region_dac2 = 3'd3;
    localparam logic [2:0] region_led  = 3'd4;

    // WS2812B pulse widths in clk cycles
    localparam int t_short = 11;
    localparam int t_long  = 22;

    localparam int fifo_depth    = 8;
    localparam int fifo_ptr_bits = 3;

    localparam int pixel_bits = 24;  // GRB, 8 bits per channel

    // One bus data word, read differently per region
    typedef union packed {
        struct packed {
            logic [4:0] red;
            logic [5:0] green;
            logic [4:0] blue;
        } rgb;

        struct packed {
            logic [13:0] pad;
            logic        scl_release;
            logic        sda_release;
        } ctrl;

        struct packed {
            logic [10:0] pad;
            logic [4:0]  code;
        } dac;
    } bus_word_u;

endpackage
